// ==== common/raster_config.svh ====
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

////////////////////
// memory map
////////////////////

// triangle records start after the colour and depth areas
`define TRI_BASE      153600
// 3 vertices x (x, y, z) x 16 bit
`define TRI_BYTES     18
`define TRI_NIBBLES   36
// second colour half, 320x240 at 2 pixels per byte
`define BACK_OFFSET   38400

////////////////////
// screen geometry
////////////////////

`define ROW_BYTES     160
// one tile is 4 pixels, one nibble each
`define TILE_NIBBLES  4

// idle cycles between start_read and the first nibble
`define READ_LATENCY  16
// display line after which the buffers may swap
`define SWAP_LINE     500

`endif

// ==== common/raster_pkg.sv ====
package raster_pkg;

  // integer screen coordinate
  typedef logic signed [19:0] coord_t;
  // edge function accumulator
  typedef logic signed [19:0] edge_t;

  // triangle record as stored, x0 holds the first nibble read
  typedef struct packed {
    logic [15:0] x0, y0, z0;
    logic [15:0] x1, y1, z1;
    logic [15:0] x2, y2, z2;
  } tri_raw_t;

  // value at the box corner, step per pixel, step per row
  typedef struct packed {
    edge_t init;
    edge_t dx;
    edge_t dy;
  } edge_coef_t;

  typedef struct packed {
    coord_t           min_x;
    coord_t           min_y;
    coord_t           max_x;
    coord_t           max_y;
    edge_coef_t [2:0] edges;
  } tri_setup_t;

  typedef enum logic {
    MEM_READ,
    MEM_WRITE
  } mem_op_t;

  typedef struct packed {
    mem_op_t     op;
    logic [23:0] addr;
    logic [5:0]  count;
    logic [15:0] wr_tile;
  } mem_cmd_t;

  // towards the serial memory
  typedef struct packed {
    logic [23:0] addr;
    logic [3:0]  wr_nibble;
    logic        start_read;
    logic        start_write;
    logic        stop;
  } mem_req_t;

  // from the serial memory
  typedef struct packed {
    logic [3:0] rd_nibble;
    logic       data_req;
    logic       notbusy;
  } mem_rsp_t;

  typedef enum logic [3:0] {
    W_IDLE, W_TRI_CHECK, W_TRI_REQ, W_TRI_WAIT, W_SETUP_WAIT, W_ROW, W_TILE,
    W_RD_REQ, W_RD_WAIT, W_PIXEL, W_WR_REQ, W_WR_WAIT, W_SWAP
  } walk_state_t;

  typedef enum logic [2:0] {
    P_IDLE, P_WAIT_LAT, P_READ, P_WRITE, P_STOP
  } port_state_t;

endpackage

// ==== list.f ====
+incdir+common
common/raster_pkg.sv
setup/tri_setup.sv
mem/mem_port.sv
src/tile_walker.sv
src/raster_top.sv
tests/ram_model.sv
tests/tb_raster.sv

// ==== mem/mem_port.sv ====
`include "raster_config.svh"

module mem_port
  import raster_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  mem_cmd_t     i_cmd,
  input  logic         i_cmd_valid,
  output logic         o_cmd_ready,
  output logic         o_done,
  output logic [143:0] o_rd_data,
  output mem_req_t     o_mem_req,
  input  mem_rsp_t     i_mem_rsp
);

  port_state_t state;
  logic [4:0]  lat_cnt;
  logic [5:0]  nib_cnt;
  logic [5:0]  nib_total;
  // nibbles still to be sent, msb first
  logic [15:0] wr_shift;
  logic        accept;

  // a busy memory holds the command in the walker
  assign o_cmd_ready = (state == P_IDLE) && i_mem_rsp.notbusy;
  assign accept = i_cmd_valid && o_cmd_ready;

  ////////////////////
  // sequencer
  ////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= P_IDLE;
      lat_cnt <= 5'd0;
      nib_cnt <= 6'd0;
      o_done <= 1'b0;
      o_mem_req <= '0;
    end else begin
      // strobes are single cycle
      o_done <= 1'b0;
      o_mem_req.start_read <= 1'b0;
      o_mem_req.start_write <= 1'b0;
      o_mem_req.stop <= 1'b0;
      case (state)
        P_IDLE: begin
          if (accept) begin
            o_mem_req.addr <= i_cmd.addr;
            lat_cnt <= 5'd0;
            if (i_cmd.op == MEM_READ) begin
              o_mem_req.start_read <= 1'b1;
              nib_cnt <= 6'd0;
              state <= P_WAIT_LAT;
            end else begin
              // first nibble goes out with the start
              o_mem_req.start_write <= 1'b1;
              o_mem_req.wr_nibble <= i_cmd.wr_tile[15:12];
              nib_cnt <= 6'd1;
              state <= P_WRITE;
            end
          end
        end
        // memory output not valid yet
        P_WAIT_LAT: begin
          if (lat_cnt == 5'(`READ_LATENCY - 1)) begin
            state <= P_READ;
          end else begin
            lat_cnt <= lat_cnt + 5'd1;
          end
        end
        // one nibble per cycle
        P_READ: begin
          nib_cnt <= nib_cnt + 6'd1;
          if (nib_cnt == nib_total - 6'd1) begin
            o_mem_req.stop <= 1'b1;
            state <= P_STOP;
          end
        end
        // data_req asks for the next nibble
        P_WRITE: begin
          if (i_mem_rsp.data_req) begin
            if (nib_cnt == nib_total) begin
              o_mem_req.stop <= 1'b1;
              state <= P_STOP;
            end else begin
              o_mem_req.wr_nibble <= wr_shift[15:12];
              nib_cnt <= nib_cnt + 6'd1;
            end
          end
        end
        P_STOP: begin
          o_done <= 1'b1;
          state <= P_IDLE;
        end
        default: state <= P_IDLE;
      endcase
    end
  end

  ////////////////////
  // shift registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      nib_total <= i_cmd.count;
      wr_shift <= {i_cmd.wr_tile[11:0], 4'd0};
      o_rd_data <= '0;
    end else if (state == P_READ) begin
      // first nibble ends up most significant
      o_rd_data <= {o_rd_data[139:0], i_mem_rsp.rd_nibble};
    end else if ((state == P_WRITE) && i_mem_rsp.data_req) begin
      wr_shift <= {wr_shift[11:0], 4'd0};
    end
  end

  a_one_start: assert property (@(posedge clk) disable iff (reset)
    !(o_mem_req.start_read && o_mem_req.start_write));

  a_no_early_stop: assert property (@(posedge clk) disable iff (reset)
    (o_mem_req.start_read || o_mem_req.start_write) |=> !o_mem_req.stop);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the rasterizer testbench, result from the log
rm -f sim.log
verilator --binary --assert -f list.f --top-module tb_raster -o sim_raster > build.log 2>&1 \
  && ./obj_dir/sim_raster > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// ==== setup/tri_setup.sv ====
module tri_setup
  import raster_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       i_start,
  input  tri_raw_t   i_tri,
  output logic       o_done,
  output tri_setup_t o_setup
);

  // vertices widened to screen coordinates
  coord_t     vx [3];
  coord_t     vy [3];
  // 1: fold v2 into box, 2..4: one edge each
  logic [2:0] stage;
  coord_t     min_x_fold;
  coord_t     max_x_fold;
  // edge from vertex a to vertex b
  logic [1:0] ia;
  logic [1:0] ib;
  coord_t     xa;
  coord_t     ya;
  coord_t     xb;
  coord_t     yb;
  edge_t      init_val;

  assign vx[0] = coord_t'({4'd0, i_tri.x0});
  assign vy[0] = coord_t'({4'd0, i_tri.y0});
  assign vx[1] = coord_t'({4'd0, i_tri.x1});
  assign vy[1] = coord_t'({4'd0, i_tri.y1});
  assign vx[2] = coord_t'({4'd0, i_tri.x2});
  assign vy[2] = coord_t'({4'd0, i_tri.y2});

  assign min_x_fold = (o_setup.min_x < vx[2]) ? o_setup.min_x : vx[2];
  assign max_x_fold = (o_setup.max_x > vx[2]) ? o_setup.max_x : vx[2];

  // edges 0->1, 1->2, 2->0
  always_comb begin
    case (stage)
      3'd3: begin
        ia = 2'd1;
        ib = 2'd2;
      end
      3'd4: begin
        ia = 2'd2;
        ib = 2'd0;
      end
      default: begin
        ia = 2'd0;
        ib = 2'd1;
      end
    endcase
  end

  assign xa = vx[ia];
  assign ya = vy[ia];
  assign xb = vx[ib];
  assign yb = vy[ib];
  // corner value, y grows downwards
  assign init_val = edge_t'((o_setup.min_x - xa) * (yb - ya) + (ya - o_setup.min_y) * (xb - xa));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      stage <= 3'd0;
      o_done <= 1'b0;
    end else begin
      o_done <= (stage == 3'd4);
      if (i_start) begin
        stage <= 3'd1;
      end else if (stage == 3'd4) begin
        stage <= 3'd0;
      end else if (stage != 3'd0) begin
        stage <= stage + 3'd1;
      end
    end
  end

  // i_tri is held by the walker until the next start
  always_ff @(posedge clk) begin
    if (i_start) begin
      o_setup.min_x <= (vx[0] < vx[1]) ? vx[0] : vx[1];
      o_setup.max_x <= (vx[0] > vx[1]) ? vx[0] : vx[1];
      o_setup.min_y <= (vy[0] < vy[1]) ? vy[0] : vy[1];
      o_setup.max_y <= (vy[0] > vy[1]) ? vy[0] : vy[1];
    end else if (stage == 3'd1) begin
      // x snapped down to the tile grid
      o_setup.min_x <= {min_x_fold[19:2], 2'b00};
      o_setup.max_x <= {max_x_fold[19:2], 2'b00};
      o_setup.min_y <= (o_setup.min_y < vy[2]) ? o_setup.min_y : vy[2];
      o_setup.max_y <= (o_setup.max_y > vy[2]) ? o_setup.max_y : vy[2];
    end else if (stage != 3'd0) begin
      o_setup.edges[ia].init <= init_val;
      o_setup.edges[ia].dx <= yb - ya;
      // subtracted once per row
      o_setup.edges[ia].dy <= xb - xa;
    end
  end

  a_setup_box: assert property (@(posedge clk) disable iff (reset)
    i_start |-> ##5 (o_done && (o_setup.min_x <= o_setup.max_x)
                     && (o_setup.min_y <= o_setup.max_y)));

endmodule

// ==== src/raster_top.sv ====
module raster_top
  import raster_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       i_start,
  input  logic [8:0] i_numtri,
  input  logic [9:0] i_y,
  input  logic       i_evenframe,
  input  mem_rsp_t   i_mem_rsp,
  output mem_req_t   o_mem_req,
  output logic       o_do_swap,
  output logic       o_running
);

  // walker <-> memory sequencer
  mem_cmd_t     cmd;
  logic         cmd_valid;
  logic         cmd_ready;
  logic         mem_done;
  logic [143:0] rd_data;
  // walker <-> triangle setup
  logic         setup_start;
  tri_raw_t     tri_raw;
  logic         setup_done;
  tri_setup_t   setup;

  tile_walker tile_walker_inst (
    .clk(clk), .reset(reset), .i_start(i_start), .i_numtri(i_numtri),
    .i_y(i_y), .i_evenframe(i_evenframe), .o_do_swap(o_do_swap),
    .o_running(o_running), .o_cmd(cmd), .o_cmd_valid(cmd_valid),
    .i_cmd_ready(cmd_ready), .i_mem_done(mem_done), .i_rd_data(rd_data),
    .o_setup_start(setup_start), .o_tri(tri_raw), .i_setup_done(setup_done),
    .i_setup(setup)
  );

  tri_setup tri_setup_inst (
    .clk(clk), .reset(reset), .i_start(setup_start), .i_tri(tri_raw),
    .o_done(setup_done), .o_setup(setup)
  );

  // only port to the serial nibble memory
  mem_port mem_port_inst (
    .clk(clk), .reset(reset), .i_cmd(cmd), .i_cmd_valid(cmd_valid),
    .o_cmd_ready(cmd_ready), .o_done(mem_done), .o_rd_data(rd_data),
    .o_mem_req(o_mem_req), .i_mem_rsp(i_mem_rsp)
  );

endmodule

// ==== src/tile_walker.sv ====
`include "raster_config.svh"

module tile_walker
  import raster_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         i_start,
  input  logic [8:0]   i_numtri,
  input  logic [9:0]   i_y,
  input  logic         i_evenframe,
  output logic         o_do_swap,
  output logic         o_running,
  output mem_cmd_t     o_cmd,
  output logic         o_cmd_valid,
  input  logic         i_cmd_ready,
  input  logic         i_mem_done,
  input  logic [143:0] i_rd_data,
  output logic         o_setup_start,
  output tri_raw_t     o_tri,
  input  logic         i_setup_done,
  input  tri_setup_t   i_setup
);

  walk_state_t state;
  logic [8:0]  tri_idx;
  coord_t      pixel_x;
  coord_t      pixel_y;
  // edge values at the start of the current row / current pixel
  edge_t       row_e [3];
  edge_t       pix_e [3];
  logic [15:0] tile;
  logic [15:0] tile_merged;
  logic [1:0]  pix_idx;
  logic [3:0]  color;
  logic        pix_in;
  logic        rows_done;
  logic        tiles_done;
  logic [23:0] tri_addr;
  logic [23:0] tile_addr;

  assign color = tri_idx[3:0] + 4'd1;
  // strictly inside, shared edges drawn by neither triangle
  assign pix_in = (pix_e[0] > 0) && (pix_e[1] > 0) && (pix_e[2] > 0);
  assign rows_done = pixel_y > i_setup.max_y;
  assign tiles_done = pixel_x > i_setup.max_x;
  assign tri_addr = 24'(`TRI_BASE) + 24'(tri_idx) * 24'(`TRI_BYTES);
  // y * 160 + x / 2, back half on even frames
  assign tile_addr = 24'(pixel_y[9:0]) * 24'(`ROW_BYTES) + 24'(pixel_x[9:1])
                   + (i_evenframe ? 24'(`BACK_OFFSET) : 24'd0);
  assign o_cmd_valid = (state == W_TRI_REQ) || (state == W_RD_REQ) || (state == W_WR_REQ);

  // pixel 0 sits in the top nibble
  always_comb begin
    tile_merged = tile;
    if (pix_in) begin
      tile_merged[{~pix_idx, 2'b00} +: 4] = color;
    end
  end

  ////////////////////
  // frame FSM
  ////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= W_IDLE;
      tri_idx <= 9'd0;
      o_running <= 1'b0;
      o_do_swap <= 1'b0;
      o_setup_start <= 1'b0;
    end else begin
      o_setup_start <= 1'b0;
      case (state)
        W_IDLE: begin
          o_do_swap <= 1'b0;
          o_running <= 1'b0;
          if (i_start) begin
            tri_idx <= 9'd0;
            o_running <= 1'b1;
            state <= W_TRI_CHECK;
          end
        end
        W_TRI_CHECK: state <= (tri_idx == i_numtri) ? W_SWAP : W_TRI_REQ;
        W_TRI_REQ: if (i_cmd_ready) state <= W_TRI_WAIT;
        W_TRI_WAIT: begin
          if (i_mem_done) begin
            o_setup_start <= 1'b1;
            state <= W_SETUP_WAIT;
          end
        end
        W_SETUP_WAIT: if (i_setup_done) state <= W_ROW;
        W_ROW: begin
          if (rows_done) begin
            tri_idx <= tri_idx + 9'd1;
            state <= W_TRI_CHECK;
          end else begin
            state <= W_TILE;
          end
        end
        W_TILE: state <= tiles_done ? W_ROW : W_RD_REQ;
        W_RD_REQ: if (i_cmd_ready) state <= W_RD_WAIT;
        W_RD_WAIT: if (i_mem_done) state <= W_PIXEL;
        W_PIXEL: if (pix_idx == 2'd3) state <= W_WR_REQ;
        W_WR_REQ: if (i_cmd_ready) state <= W_WR_WAIT;
        W_WR_WAIT: if (i_mem_done) state <= W_TILE;
        // all triangles drawn, wait for blanking
        W_SWAP: begin
          if (i_y > `SWAP_LINE) begin
            o_do_swap <= 1'b1;
            state <= W_IDLE;
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  ////////////////////
  // scan datapath
  ////////////////////
  always_ff @(posedge clk) begin
    case (state)
      W_TRI_CHECK: o_cmd <= '{MEM_READ, tri_addr, 6'(`TRI_NIBBLES), 16'd0};
      W_TRI_WAIT: if (i_mem_done) o_tri <= tri_raw_t'(i_rd_data);
      W_SETUP_WAIT: begin
        pixel_y <= i_setup.min_y;
        for (int k = 0; k < 3; k++) begin
          row_e[k] <= i_setup.edges[k].init;
        end
      end
      // restart x, move the row values one line down
      W_ROW: begin
        pixel_x <= i_setup.min_x;
        for (int k = 0; k < 3; k++) begin
          pix_e[k] <= row_e[k];
          row_e[k] <= row_e[k] - i_setup.edges[k].dy;
        end
      end
      W_TILE: begin
        if (tiles_done) begin
          pixel_y <= pixel_y + 20'sd1;
        end else begin
          o_cmd <= '{MEM_READ, tile_addr, 6'(`TILE_NIBBLES), 16'd0};
        end
      end
      W_RD_WAIT: begin
        tile <= i_rd_data[15:0];
        pix_idx <= 2'd0;
      end
      // one pixel per cycle, write back after the fourth
      W_PIXEL: begin
        tile <= tile_merged;
        pix_idx <= pix_idx + 2'd1;
        for (int k = 0; k < 3; k++) begin
          pix_e[k] <= pix_e[k] + i_setup.edges[k].dx;
        end
        if (pix_idx == 2'd3) begin
          o_cmd <= '{MEM_WRITE, tile_addr, 6'(`TILE_NIBBLES), tile_merged};
        end
      end
      W_WR_WAIT: if (i_mem_done) pixel_x <= pixel_x + 20'sd4;
      default: ;
    endcase
  end

  // box from tri_setup keeps every tile on the 4-pixel grid
  a_tile_grid: assert property (@(posedge clk) disable iff (reset)
    (state == W_RD_REQ) |-> (pixel_x[1:0] == 2'b00));

endmodule

// ==== tests/ram_model.sv ====
`include "raster_config.svh"

module ram_model
  import raster_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  mem_req_t    i_req,
  input  logic        i_gap,
  output mem_rsp_t    o_rsp,
  output logic        o_wr_done,
  output logic [23:0] o_wr_addr,
  output logic [15:0] o_wr_tile,
  output logic [3:0]  o_wr_count
);

  // colour halves plus room for eight triangle records
  localparam int MEM_NIBBLES = 2 * (`TRI_BASE + 8 * `TRI_BYTES);

  logic [3:0] mem [0:MEM_NIBBLES-1];
  logic       rd_active;
  logic       wr_active;
  int         base;
  int         ptr;
  int         wait_cnt;
  logic [1:0] wr_phase;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      o_rsp <= '0;
      rd_active <= 1'b0;
      wr_active <= 1'b0;
      wr_phase <= 2'd0;
      o_wr_done <= 1'b0;
      o_wr_addr <= 24'd0;
      o_wr_tile <= 16'd0;
      o_wr_count <= 4'd0;
    end else begin
      o_wr_done <= 1'b0;
      o_rsp.data_req <= 1'b0;
      // busy during a transaction and on random gap cycles
      o_rsp.notbusy <= !i_gap && !rd_active && !wr_active
                       && !i_req.start_read && !i_req.start_write;
      ////////////////////
      // read side
      ////////////////////
      if (i_req.start_read) begin
        rd_active <= 1'b1;
        base <= 2 * int'(i_req.addr);
        ptr <= 0;
        wait_cnt <= `READ_LATENCY - 2;
      end else if (rd_active) begin
        if (i_req.stop) begin
          rd_active <= 1'b0;
        end else if (wait_cnt != 0) begin
          wait_cnt <= wait_cnt - 1;
        end else begin
          o_rsp.rd_nibble <= mem[base + ptr];
          ptr <= ptr + 1;
        end
      end
      ////////////////////
      // write side
      ////////////////////
      if (i_req.start_write) begin
        // first nibble comes with the start
        wr_active <= 1'b1;
        base <= 2 * int'(i_req.addr);
        mem[2 * int'(i_req.addr)] = i_req.wr_nibble;
        o_wr_addr <= i_req.addr;
        o_wr_tile <= {12'd0, i_req.wr_nibble};
        o_wr_count <= 4'd1;
        wr_phase <= 2'd0;
      end else if (wr_active) begin
        case (wr_phase)
          2'd0: begin
            if (!i_gap) begin
              o_rsp.data_req <= 1'b1;
              wr_phase <= 2'd1;
            end
          end
          // port presents the next nibble here
          2'd1: wr_phase <= 2'd2;
          default: begin
            wr_phase <= 2'd0;
            if (i_req.stop) begin
              wr_active <= 1'b0;
              o_wr_done <= 1'b1;
            end else begin
              mem[base + int'(o_wr_count)] = i_req.wr_nibble;
              o_wr_tile <= {o_wr_tile[11:0], i_req.wr_nibble};
              o_wr_count <= o_wr_count + 4'd1;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== tests/tb_raster.sv ====
`include "raster_config.svh"

module tb_raster
  import raster_pkg::*;
();

  localparam int NTRI = 3;
  localparam logic [31:0] SEED = 32'h0e94_c058;
  // at most 5 x 13 tiles per box over two frames
  localparam int TIMEOUT = 2 * NTRI * 5 * 13 * 80 + 2000;

  logic        clk = 1'b0;
  logic        reset;
  logic        i_start;
  logic [8:0]  i_numtri;
  logic [9:0]  i_y = 10'd0;
  logic        i_evenframe;
  mem_rsp_t    mem_rsp;
  mem_req_t    mem_req;
  logic        o_do_swap;
  logic        o_running;
  logic        gap = 1'b0;
  logic        wr_done;
  logic [23:0] wr_addr;
  logic [15:0] wr_tile;
  logic [3:0]  wr_count;

  logic [31:0] tri_seed;
  logic [31:0] gap_seed = SEED;
  int          vx [NTRI][3];
  int          vy [NTRI][3];
  logic [3:0]  shadow [int];
  int          cycles = 0;
  int          mismatches = 0;
  int          proto_errs = 0;
  int          frame_errs = 0;
  int          swap_cnt = 0;
  int          cur_tri = 0;
  logic        started = 1'b0;
  logic        prev_notbusy = 1'b0;
  logic        prev_data_req = 1'b0;
  logic        prev_swap = 1'b0;
  logic [3:0]  prev_wr_nibble = 4'd0;
  logic [9:0]  prev_y = 10'd0;

  raster_top raster_top_inst (
    .clk(clk), .reset(reset), .i_start(i_start), .i_numtri(i_numtri), .i_y(i_y),
    .i_evenframe(i_evenframe), .i_mem_rsp(mem_rsp), .o_mem_req(mem_req),
    .o_do_swap(o_do_swap), .o_running(o_running)
  );

  ram_model ram_model_inst (
    .clk(clk), .reset(reset), .i_req(mem_req), .i_gap(gap), .o_rsp(mem_rsp),
    .o_wr_done(wr_done), .o_wr_addr(wr_addr), .o_wr_tile(wr_tile), .o_wr_count(wr_count)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] next_lcg(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function int draw(int n);
    tri_seed = next_lcg(tri_seed);
    return int'(tri_seed[31:16]) % n;
  endfunction

  // mixes every address bit into the nibble
  function automatic logic [3:0] fill_nibble(int a);
    logic [31:0] u;
    u = a;
    return u[3:0] ^ u[7:4] ^ u[11:8] ^ u[15:12] ^ u[19:16] ^ {3'd0, u[20]};
  endfunction

  function automatic int edge_val(int px, int py, int xa, int ya, int xb, int yb);
    return (px - xa) * (yb - ya) - (py - ya) * (xb - xa);
  endfunction

  function automatic logic covered(int t, int px, int py);
    return edge_val(px, py, vx[t][0], vy[t][0], vx[t][1], vy[t][1]) > 0
        && edge_val(px, py, vx[t][1], vy[t][1], vx[t][2], vy[t][2]) > 0
        && edge_val(px, py, vx[t][2], vy[t][2], vx[t][0], vy[t][0]) > 0;
  endfunction

  task automatic make_triangle(int t);
    int bx;
    int by;
    int tmp;
    logic [15:0] words [9];
    int nib;
    bx = 8 + draw(280);
    by = 8 + draw(200);
    vx[t][0] = bx + draw(4);
    vy[t][0] = by + draw(4);
    vx[t][1] = bx + draw(5);
    vy[t][1] = by + 10 + draw(3);
    vx[t][2] = bx + 9 + draw(4);
    vy[t][2] = by + draw(12);
    // counter-clockwise on a y-down screen
    if (edge_val(vx[t][2], vy[t][2], vx[t][0], vy[t][0], vx[t][1], vy[t][1]) <= 0) begin
      tmp = vx[t][1];
      vx[t][1] = vx[t][2];
      vx[t][2] = tmp;
      tmp = vy[t][1];
      vy[t][1] = vy[t][2];
      vy[t][2] = tmp;
    end
    for (int v = 0; v < 3; v++) begin
      words[3 * v] = 16'(vx[t][v]);
      words[3 * v + 1] = 16'(vy[t][v]);
      // depth is carried but unused
      words[3 * v + 2] = 16'(draw(65536));
    end
    nib = 2 * (`TRI_BASE + t * `TRI_BYTES);
    for (int w = 0; w < 9; w++) begin
      for (int j = 0; j < 4; j++) begin
        ram_model_inst.mem[nib + 4 * w + j] = words[w][15 - 4 * j -: 4];
      end
    end
  endtask

  // random memory busy gaps and the display line
  always @(posedge clk) begin
    gap_seed <= next_lcg(gap_seed);
    gap <= (gap_seed[29:28] == 2'd0);
    i_y <= (i_y == 10'd524) ? 10'd0 : i_y + 10'd1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("timeout after %0d cycles without finishing both frames", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////
  // checks
  ////////////////////
  always @(posedge clk) begin : check_outputs
    int offs;
    int py;
    int bx;
    int n;
    int miny;
    int maxy;
    logic [3:0] got;
    logic [3:0] exp_nib;
    if (!reset) begin
      if (!started) begin
        assert (!mem_req.start_read && !mem_req.start_write && !mem_req.stop
                && !o_do_swap && !o_running)
        else begin
          proto_errs++;
          $display("strobe or running active before start at %0t", $time);
        end
      end
      assert (!(mem_req.start_read || mem_req.start_write) || prev_notbusy)
      else begin
        proto_errs++;
        $display("transfer started while memory was busy at %0t", $time);
      end
      assert (mem_req.wr_nibble == prev_wr_nibble || mem_req.start_write || prev_data_req)
      else begin
        proto_errs++;
        $display("write nibble changed without data request at %0t", $time);
      end
      if (mem_req.start_read && int'(mem_req.addr) >= `TRI_BASE) begin
        cur_tri <= (int'(mem_req.addr) - `TRI_BASE) / `TRI_BYTES;
      end
      if (wr_done) begin
        assert (wr_count == 4'd4)
        else begin
          proto_errs++;
          $display("write of %0d nibbles instead of 4 at %0t", wr_count, $time);
        end
        assert ((int'(wr_addr) >= `BACK_OFFSET) == i_evenframe)
        else begin
          proto_errs++;
          $display("write address %0d in the wrong buffer half at %0t", wr_addr, $time);
        end
        offs = int'(wr_addr) - (i_evenframe ? `BACK_OFFSET : 0);
        py = offs / `ROW_BYTES;
        bx = offs % `ROW_BYTES;
        miny = vy[cur_tri][0];
        maxy = vy[cur_tri][0];
        for (int v = 1; v < 3; v++) begin
          miny = (vy[cur_tri][v] < miny) ? vy[cur_tri][v] : miny;
          maxy = (vy[cur_tri][v] > maxy) ? vy[cur_tri][v] : maxy;
        end
        assert (bx % 2 == 0 && py >= miny && py <= maxy)
        else begin
          proto_errs++;
          $display("write address %0d outside the triangle box grid at %0t", wr_addr, $time);
        end
        for (int k = 0; k < 4; k++) begin
          n = 2 * int'(wr_addr) + k;
          got = wr_tile[15 - 4 * k -: 4];
          exp_nib = shadow.exists(n) ? shadow[n] : fill_nibble(n);
          if (covered(cur_tri, 2 * bx + k, py)) begin
            exp_nib = 4'(cur_tri + 1);
          end
          assert (got == exp_nib)
          else begin
            mismatches++;
            $display("mismatch at %0t: wr_nibble %0d of address %0d got %h expected %h",
                     $time, k, wr_addr, got, exp_nib);
          end
          shadow[n] = got;
        end
      end
      if (o_do_swap) begin
        swap_cnt <= swap_cnt + 1;
        assert (prev_y > 10'(`SWAP_LINE) && cur_tri == NTRI - 1)
        else begin
          proto_errs++;
          $display("swap before the last triangle or outside blanking at %0t", $time);
        end
      end
      // running drops the cycle after the swap pulse
      assert (!prev_swap || !o_running)
      else begin
        proto_errs++;
        $display("running still high after the swap at %0t", $time);
      end
    end
    prev_notbusy <= mem_rsp.notbusy;
    prev_data_req <= mem_rsp.data_req;
    prev_wr_nibble <= mem_req.wr_nibble;
    prev_y <= i_y;
    prev_swap <= o_do_swap;
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    reset <= 1'b1;
    i_start <= 1'b0;
    i_numtri <= 9'(NTRI);
    i_evenframe <= 1'b1;
    tri_seed = SEED;
    @(posedge clk);
    for (int a = 0; a < 2 * (`TRI_BASE + 8 * `TRI_BYTES); a++) begin
      ram_model_inst.mem[a] = fill_nibble(a);
    end
    for (int t = 0; t < NTRI; t++) begin
      make_triangle(t);
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    // back half first and the front half after
    for (int f = 0; f < 2; f++) begin
      i_evenframe <= (f == 0);
      @(posedge clk);
      i_start <= 1'b1;
      started <= 1'b1;
      @(posedge clk);
      i_start <= 1'b0;
      @(posedge clk);
      assert (o_running)
      else begin
        frame_errs++;
        $display("running not raised one cycle after start in frame %0d", f);
      end
      while (!o_do_swap) begin
        @(posedge clk);
      end
      repeat (4) @(posedge clk);
      assert (swap_cnt == f + 1 && !o_running)
      else begin
        frame_errs++;
        $display("frame %0d ended with %0d swap pulses", f, swap_cnt);
      end
    end
    $display("errors: %0d mismatch, %0d protocol, %0d frame",
             mismatches, proto_errs, frame_errs);
    if (mismatches + proto_errs + frame_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
